/* design/mipsCore_defs.svh */
`ifndef MIPSCORE_DEFS_SVH
`define MIPSCORE_DEFS_SVH

// ======================================================================
// core dimensions
// ======================================================================

// width of every register, operand and result word
`define DATA_W 32

// number of architectural registers, register 0 is hardwired to zero
`define REG_N 32

// ======================================================================
// architectural register indices
// ======================================================================

// jal writes its return address here
`define LINK_REG 31

// syscall reports these two registers
`define V0_REG 2
`define A0_REG 4

`endif

/* design/mipsCorePkg.sv */
package mipsCorePkg;

    // ==================================================================
    // instruction encodings
    // ==================================================================

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_JAL  = 6'h03, OP_ADDI = 6'h08,
        OP_SLTI    = 6'h0a, OP_ANDI = 6'h0c, OP_ORI  = 6'h0d,
        OP_LUI     = 6'h0f
    } opcodeT;

    // funct field of the SPECIAL opcode
    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA     = 6'h03,
        FN_JR  = 6'h08, FN_SYSCALL = 6'h0c,
        FN_ADD = 6'h20, FN_SUB = 6'h22, FN_AND     = 6'h24,
        FN_OR  = 6'h25, FN_SLT = 6'h2a
    } functT;

    // operation performed in the execute stage
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS
    } aluOpT;

    // ==================================================================
    // instruction word, R-format and I-format views of the same bits
    // ==================================================================

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instrT;

endpackage

/* design/regFile.sv */
`include "mipsCore_defs.svh"

module regFile (
    input  logic               clk,
    input  logic               arstN,
    input  logic [4:0]         rdAddrA,
    input  logic [4:0]         rdAddrB,
    output logic [`DATA_W-1:0] rdDataA,
    output logic [`DATA_W-1:0] rdDataB,
    output logic [`DATA_W-1:0] vData,
    output logic [`DATA_W-1:0] aData,
    input  logic               wrEn,
    input  logic [4:0]         wrAddr,
    input  logic [`DATA_W-1:0] wrData
);
    logic [`DATA_W-1:0] regs [`REG_N];

    // a read of the register being written returns the new value,
    // so an instruction two behind the writer sees its result
    function automatic logic [`DATA_W-1:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0)
            readPort = '0;
        else if (wrEn && wrAddr == addr)
            readPort = wrData;
        else
            readPort = regs[addr];
    endfunction

    always_comb
    begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
        vData   = readPort(5'(`V0_REG));
        aData   = readPort(5'(`A0_REG));
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int n = 0; n < `REG_N; n++)
                regs[n] <= '0;
        end
        else if (wrEn && wrAddr != 5'd0)
        begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

/* design/instrDecoder.sv */
`include "mipsCore_defs.svh"

module instrDecoder (
    input  logic                instrValid,
    input  mipsCorePkg::instrT  instr,
    input  logic [`DATA_W-1:0]  pc,
    output logic [4:0]          rfAddrA,
    output logic [4:0]          rfAddrB,
    input  logic [`DATA_W-1:0]  rfDataA,
    input  logic [`DATA_W-1:0]  rfDataB,
    input  logic [`DATA_W-1:0]  rfV,
    input  logic [`DATA_W-1:0]  rfA,
    output logic                valid,
    output logic                regWrite,
    output mipsCorePkg::aluOpT  aluOp,
    output logic                aluSrc,
    output logic                regDst,
    output logic                jal,
    output logic                jr,
    output logic                sys,
    output logic [`DATA_W-1:0]  data1,
    output logic [`DATA_W-1:0]  data2,
    output logic [4:0]          rs,
    output logic [4:0]          rt,
    output logic [4:0]          rd,
    output logic [4:0]          shamt,
    output logic [`DATA_W-1:0]  imm,
    output logic [`DATA_W-1:0]  pcPlus4,
    output logic [`DATA_W-1:0]  regV,
    output logic [`DATA_W-1:0]  regA
);
    import mipsCorePkg::*;

    logic                supported;
    logic [`DATA_W-1:0]  immSext;
    logic [`DATA_W-1:0]  immZext;

    assign immSext = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
    assign immZext = {{(`DATA_W-16){1'b0}}, instr.i.imm};

    // operand fields and register reads do not depend on the opcode
    assign rfAddrA = instr.r.rs;
    assign rfAddrB = instr.i.rt;
    assign rs      = instr.r.rs;
    assign rt      = instr.i.rt;
    assign shamt   = instr.r.shamt;
    assign data1   = rfDataA;
    assign data2   = rfDataB;
    assign regV    = rfV;
    assign regA    = rfA;
    assign pcPlus4 = pc + `DATA_W'(4);
    assign valid   = instrValid && supported;

    always_comb
    begin
        supported = 1'b1;
        regWrite  = 1'b0;
        aluOp     = ALU_PASS;
        aluSrc    = 1'b0;
        regDst    = 1'b0;
        jal       = 1'b0;
        jr        = 1'b0;
        sys       = 1'b0;
        rd        = instr.r.rd;
        imm       = immZext;
        case (instr.i.opcode)
            OP_SPECIAL:
            begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (instr.r.funct)
                    FN_ADD:     aluOp = ALU_ADD;
                    FN_SUB:     aluOp = ALU_SUB;
                    FN_AND:     aluOp = ALU_AND;
                    FN_OR:      aluOp = ALU_OR;
                    FN_SLT:     aluOp = ALU_SLT;
                    FN_SLL:     aluOp = ALU_SLL;
                    FN_SRL:     aluOp = ALU_SRL;
                    FN_SRA:     aluOp = ALU_SRA;
                    FN_JR:
                    begin
                        regWrite = 1'b0;
                        jr       = 1'b1;
                    end
                    FN_SYSCALL:
                    begin
                        regWrite = 1'b0;
                        sys      = 1'b1;
                    end
                    default:    supported = 1'b0;
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (instr.i.opcode)
                    OP_ADDI: aluOp = ALU_ADD;
                    OP_SLTI: aluOp = ALU_SLT;
                    OP_ANDI: aluOp = ALU_AND;
                    OP_ORI:  aluOp = ALU_OR;
                    default: aluOp = ALU_LUI;
                endcase
                if (instr.i.opcode == OP_ADDI || instr.i.opcode == OP_SLTI)
                    imm = immSext;
            end
            // the link value is pc+4, passed through the ALU into $ra
            OP_JAL:
            begin
                regWrite = 1'b1;
                regDst   = 1'b1;
                jal      = 1'b1;
                rd       = 5'(`LINK_REG);
            end
            default: supported = 1'b0;
        endcase
    end

endmodule

/* design/decodeExecReg.sv */
`include "mipsCore_defs.svh"

module decodeExecReg (
    input  logic                clk,
    input  logic                arstN,
    input  logic                flush,
    input  logic                valid,
    input  logic                regWrite,
    input  mipsCorePkg::aluOpT  aluOp,
    input  logic                aluSrc,
    input  logic                regDst,
    input  logic                jal,
    input  logic                jr,
    input  logic                sys,
    input  logic [`DATA_W-1:0]  data1,
    input  logic [`DATA_W-1:0]  data2,
    input  logic [4:0]          rs,
    input  logic [4:0]          rt,
    input  logic [4:0]          rd,
    input  logic [4:0]          shamt,
    input  logic [`DATA_W-1:0]  imm,
    input  logic [`DATA_W-1:0]  pcPlus4,
    input  logic [`DATA_W-1:0]  regV,
    input  logic [`DATA_W-1:0]  regA,
    output logic                validE,
    output logic                regWriteE,
    output mipsCorePkg::aluOpT  aluOpE,
    output logic                aluSrcE,
    output logic                regDstE,
    output logic                jalE,
    output logic                jrE,
    output logic                sysE,
    output logic [`DATA_W-1:0]  data1E,
    output logic [`DATA_W-1:0]  data2E,
    output logic [4:0]          rsE,
    output logic [4:0]          rtE,
    output logic [4:0]          rdE,
    output logic [4:0]          shamtE,
    output logic [`DATA_W-1:0]  immE,
    output logic [`DATA_W-1:0]  pcPlus4E,
    output logic [`DATA_W-1:0]  regVE,
    output logic [`DATA_W-1:0]  regAE
);
    import mipsCorePkg::*;

    // seven flags, four register indices, six data words and the operation
    localparam int opW    = $bits(aluOpT);
    localparam int stageW = 7 + 4 * 5 + 6 * `DATA_W + opW;

    logic [stageW-1:0] stageD;
    logic [stageW-1:0] stageQ;

    // an all-zero slot is a bubble, valid low and every field cleared
    assign stageD = flush ? '0 : {valid, regWrite, aluSrc, regDst, jal, jr, sys,
                                  rs, rt, rd, shamt,
                                  data1, data2, imm, pcPlus4, regV, regA, aluOp};

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            stageQ <= '0;
        else
            stageQ <= stageD;
    end

    assign {validE, regWriteE, aluSrcE, regDstE, jalE, jrE, sysE,
            rsE, rtE, rdE, shamtE,
            data1E, data2E, immE, pcPlus4E, regVE, regAE} = stageQ[stageW-1:opW];
    assign aluOpE = aluOpT'(stageQ[opW-1:0]);

endmodule

/* design/execUnit.sv */
`include "mipsCore_defs.svh"

module execUnit (
    input  logic                clk,
    input  logic                arstN,
    input  logic                validE,
    input  logic                regWriteE,
    input  mipsCorePkg::aluOpT  aluOpE,
    input  logic                aluSrcE,
    input  logic                regDstE,
    input  logic                jalE,
    input  logic                jrE,
    input  logic                sysE,
    input  logic [`DATA_W-1:0]  data1E,
    input  logic [`DATA_W-1:0]  data2E,
    input  logic [4:0]          rsE,
    input  logic [4:0]          rtE,
    input  logic [4:0]          rdE,
    input  logic [4:0]          shamtE,
    input  logic [`DATA_W-1:0]  immE,
    input  logic [`DATA_W-1:0]  pcPlus4E,
    input  logic [`DATA_W-1:0]  regVE,
    input  logic [`DATA_W-1:0]  regAE,
    output logic                resultValid,
    output logic [`DATA_W-1:0]  resultData,
    output logic [4:0]          resultReg,
    output logic                jumpValid,
    output logic [`DATA_W-1:0]  jumpTarget,
    output logic                sysValid,
    output logic [`DATA_W-1:0]  sysV,
    output logic [`DATA_W-1:0]  sysA
);
    import mipsCorePkg::*;

    logic [`DATA_W-1:0] fwdA, fwdB, fwdV, fwdArg;
    logic [`DATA_W-1:0] srcA, srcB, aluOut;
    logic [4:0]         destReg;

    // resultValid is never raised for register 0, so zero is never forwarded
    function automatic logic [`DATA_W-1:0] forward(input logic [4:0] idx,
                                                   input logic [`DATA_W-1:0] regVal);
        if (resultValid && resultReg == idx)
            forward = resultData;
        else
            forward = regVal;
    endfunction

    // ==================================================================
    // operand selection and ALU
    // ==================================================================

    always_comb
    begin
        fwdA   = forward(rsE, data1E);
        fwdB   = forward(rtE, data2E);
        fwdV   = forward(5'(`V0_REG), regVE);
        fwdArg = forward(5'(`A0_REG), regAE);
        srcA   = jalE ? pcPlus4E : fwdA;
        srcB   = aluSrcE ? immE : fwdB;
        case (aluOpE)
            ALU_ADD:  aluOut = srcA + srcB;
            ALU_SUB:  aluOut = srcA - srcB;
            ALU_AND:  aluOut = srcA & srcB;
            ALU_OR:   aluOut = srcA | srcB;
            ALU_SLT:  aluOut = {{(`DATA_W-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLL:  aluOut = srcB << shamtE;
            ALU_SRL:  aluOut = srcB >> shamtE;
            ALU_SRA:  aluOut = $signed(srcB) >>> shamtE;
            ALU_LUI:  aluOut = {srcB[15:0], {(`DATA_W-16){1'b0}}};
            default:  aluOut = srcA;
        endcase
    end

    assign destReg = regDstE ? rdE : rtE;

    // ==================================================================
    // result, jump and syscall strobes
    // ==================================================================

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            resultValid <= 1'b0;
            resultData  <= '0;
            resultReg   <= '0;
            jumpValid   <= 1'b0;
            jumpTarget  <= '0;
            sysValid    <= 1'b0;
            sysV        <= '0;
            sysA        <= '0;
        end
        else
        begin
            resultValid <= validE && regWriteE && destReg != 5'd0;
            resultData  <= aluOut;
            resultReg   <= destReg;
            jumpValid   <= validE && jrE;
            jumpTarget  <= fwdA;
            sysValid    <= validE && sysE;
            sysV        <= fwdV;
            sysA        <= fwdArg;
        end
    end

endmodule

/* design/mipsCore.sv */
`include "mipsCore_defs.svh"

module mipsCore (
    input  logic                clk,
    input  logic                arstN,
    input  logic                instrValid,
    input  mipsCorePkg::instrT  instr,
    input  logic [`DATA_W-1:0]  pc,
    input  logic                flush,
    output logic                resultValid,
    output logic [`DATA_W-1:0]  resultData,
    output logic [4:0]          resultReg,
    output logic                jumpValid,
    output logic [`DATA_W-1:0]  jumpTarget,
    output logic                sysValid,
    output logic [`DATA_W-1:0]  sysV,
    output logic [`DATA_W-1:0]  sysA
);
    import mipsCorePkg::*;

    // register file read side
    logic [4:0]         rfAddrA, rfAddrB;
    logic [`DATA_W-1:0] rfDataA, rfDataB, rfV, rfA;

    // decode stage outputs
    logic               valid, regWrite, aluSrc, regDst, jal, jr, sys;
    aluOpT              aluOp;
    logic [4:0]         rs, rt, rd, shamt;
    logic [`DATA_W-1:0] data1, data2, imm, pcPlus4, regV, regA;

    // execute stage inputs
    logic               validE, regWriteE, aluSrcE, regDstE, jalE, jrE, sysE;
    aluOpT              aluOpE;
    logic [4:0]         rsE, rtE, rdE, shamtE;
    logic [`DATA_W-1:0] data1E, data2E, immE, pcPlus4E, regVE, regAE;

    // the result strobe doubles as the register file write port
    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (rfAddrA),
        .rdAddrB (rfAddrB),
        .rdDataA (rfDataA),
        .rdDataB (rfDataB),
        .vData   (rfV),
        .aData   (rfA),
        .wrEn    (resultValid),
        .wrAddr  (resultReg),
        .wrData  (resultData)
    );

    instrDecoder uDecoder (.*);

    decodeExecReg uDecodeExec (.*);

    execUnit uExec (.*);

endmodule

/* tb/mipsCore_asserts.sv */
module mipsCore_asserts (
    input logic clk,
    input logic arstN,
    input logic instrValid,
    input logic flush,
    input logic resultValid,
    input logic jumpValid,
    input logic sysValid
);

    // the first clocked result after reset release comes from the cleared pipeline register
    resultLowAfterReset: assert property (@(posedge clk) $rose(arstN) |=> !resultValid)
        else $error("resultValid high in the cycle after reset");

    // every strobe comes from an instruction accepted two edges earlier
    strobeHasSource: assert property (@(posedge clk) disable iff (!arstN)
        (resultValid || jumpValid || sysValid) |-> $past(instrValid && !flush, 2))
        else $error("output strobe without an accepted instruction two cycles before");

    oneStrobeAtATime: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({resultValid, jumpValid, sysValid}))
        else $error("more than one output strobe high in the same cycle");

endmodule

bind mipsCore mipsCore_asserts uAsserts (
    .clk         (clk),
    .arstN       (arstN),
    .instrValid  (instrValid),
    .flush       (flush),
    .resultValid (resultValid),
    .jumpValid   (jumpValid),
    .sysValid    (sysValid)
);

/* tb/mipsCoreTb.sv */
`include "mipsCore_defs.svh"

module mipsCoreTb;
    import mipsCorePkg::*;

    localparam int NUM_INSTR = 2000;
    // at most two cycles per instruction, plus reset, drain and slack
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 2 + 2000;

    typedef enum logic [1:0] {EV_NONE, EV_RESULT, EV_JUMP, EV_SYS} eventT;

    logic               clk;
    logic               arstN;
    logic               instrValid;
    instrT              instr;
    logic [`DATA_W-1:0] pc;
    logic               flush;
    logic               resultValid;
    logic [`DATA_W-1:0] resultData;
    logic [4:0]         resultReg;
    logic               jumpValid;
    logic [`DATA_W-1:0] jumpTarget;
    logic               sysValid;
    logic [`DATA_W-1:0] sysV;
    logic [`DATA_W-1:0] sysA;

    integer             seed;
    int                 cycleCount = 0;
    logic               checking;
    int                 checks, valueErrors, otherErrors;
    int                 resultSeen, jumpSeen, sysSeen, flushSeen;

    logic [`DATA_W-1:0] modelRegs [`REG_N];

    // expected strobe per cycle, written two cycles before it is checked
    eventT              expKind [4];
    logic [`DATA_W-1:0] expData [4];
    logic [4:0]         expReg [4];
    logic [`DATA_W-1:0] expV [4];
    logic [`DATA_W-1:0] expA [4];

    mipsCore u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    initial
    begin
        wait (cycleCount >= TIMEOUT_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ======================================================================
    // stimulus generation and reference model
    // ======================================================================

    // mostly a small pool of registers so that dependent pairs are common
    function automatic logic [4:0] pickReg(input logic [7:0] r);
        if (r[7:6] == 2'b00)
            pickReg = r[4:0];
        else
            pickReg = {2'b00, r[2:0]};
    endfunction

    function automatic instrT makeInstr();
        logic [31:0] sel;
        logic [31:0] bits;
        instrT       w;
        sel  = $random(seed);
        bits = $random(seed);
        w    = bits;
        w.r.rs = pickReg(sel[7:0]);
        w.r.rt = pickReg(sel[15:8]);
        w.r.rd = pickReg(sel[23:16]);
        if (sel[31:27] < 5'd10)
        begin
            w.r.opcode = OP_SPECIAL;
            case (sel[26:24])
                3'd0:    w.r.funct = FN_ADD;
                3'd1:    w.r.funct = FN_SUB;
                3'd2:    w.r.funct = FN_AND;
                3'd3:    w.r.funct = FN_OR;
                default: w.r.funct = FN_SLT;
            endcase
        end
        else if (sel[31:27] < 5'd14)
        begin
            w.r.opcode = OP_SPECIAL;
            case (sel[25:24])
                2'd0:    w.r.funct = FN_SLL;
                2'd1:    w.r.funct = FN_SRL;
                default: w.r.funct = FN_SRA;
            endcase
        end
        else if (sel[31:27] < 5'd25)
        begin
            case (sel[26:24])
                3'd0:    w.i.opcode = OP_ANDI;
                3'd1:    w.i.opcode = OP_ORI;
                3'd2:    w.i.opcode = OP_SLTI;
                3'd3:    w.i.opcode = OP_LUI;
                default: w.i.opcode = OP_ADDI;
            endcase
        end
        else if (sel[31:27] < 5'd27)
            w.i.opcode = OP_JAL;
        else
        begin
            w.r.opcode = OP_SPECIAL;
            w.r.funct  = (sel[31:27] < 5'd29) ? FN_JR : FN_SYSCALL;
        end
        makeInstr = w;
    endfunction

    function automatic void modelInstr(input instrT w, input logic [31:0] pcVal,
                                       output eventT kind, output logic [31:0] data,
                                       output logic [4:0] dest, output logic [31:0] vOut,
                                       output logic [31:0] aOut);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        a    = modelRegs[w.r.rs];
        b    = modelRegs[w.r.rt];
        sext = {{16{w.i.imm[15]}}, w.i.imm};
        zext = {16'h0000, w.i.imm};
        kind = EV_RESULT;
        data = '0;
        vOut = modelRegs[`V0_REG];
        aOut = modelRegs[`A0_REG];
        if (w.r.opcode == OP_SPECIAL)
        begin
            dest = w.r.rd;
            case (w.r.funct)
                FN_ADD:  data = a + b;
                FN_SUB:  data = a - b;
                FN_AND:  data = a & b;
                FN_OR:   data = a | b;
                FN_SLT:  data = {31'd0, $signed(a) < $signed(b)};
                FN_SLL:  data = b << w.r.shamt;
                FN_SRL:  data = b >> w.r.shamt;
                FN_SRA:  data = $signed(b) >>> w.r.shamt;
                FN_JR:
                begin
                    kind = EV_JUMP;
                    data = a;
                end
                default: kind = EV_SYS;
            endcase
        end
        else
        begin
            dest = w.i.rt;
            case (w.i.opcode)
                OP_ADDI: data = a + sext;
                OP_SLTI: data = {31'd0, $signed(a) < $signed(sext)};
                OP_ANDI: data = a & zext;
                OP_ORI:  data = a | zext;
                OP_LUI:  data = {w.i.imm, 16'h0000};
                default:
                begin
                    dest = 5'(`LINK_REG);
                    data = pcVal + 32'd4;
                end
            endcase
        end
        // register 0 stays zero and raises no result strobe
        if (kind == EV_RESULT)
        begin
            if (dest == 5'd0)
                kind = EV_NONE;
            else
                modelRegs[dest] = data;
        end
    endfunction

    // ======================================================================
    // comparison
    // ======================================================================

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic compareSlot(input logic [1:0] s);
        checkWord("resultValid", 32'(resultValid), 32'(expKind[s] == EV_RESULT));
        checkWord("jumpValid", 32'(jumpValid), 32'(expKind[s] == EV_JUMP));
        checkWord("sysValid", 32'(sysValid), 32'(expKind[s] == EV_SYS));
        if (resultValid && expKind[s] == EV_RESULT)
        begin
            checkWord("resultData", resultData, expData[s]);
            checkWord("resultReg", 32'(resultReg), 32'(expReg[s]));
            resultSeen++;
        end
        if (jumpValid && expKind[s] == EV_JUMP)
        begin
            checkWord("jumpTarget", jumpTarget, expData[s]);
            jumpSeen++;
        end
        if (sysValid && expKind[s] == EV_SYS)
        begin
            checkWord("sysV", sysV, expV[s]);
            checkWord("sysA", sysA, expA[s]);
            sysSeen++;
        end
        assert (!(resultValid && resultReg == 5'd0))
        else
        begin
            $display("a result strobe targets register 0 at time %0t", $time);
            otherErrors++;
        end
    endtask

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (checking)
                compareSlot(2'(cycleCount));
        end
    end

    // ======================================================================
    // main sequence
    // ======================================================================

    initial
    begin
        logic [31:0] r;
        logic [31:0] pcNext;
        logic [1:0]  slot;
        logic        doIssue;
        logic        doFlush;
        instrT       w;
        seed        = 32'he671_c5ca;
        arstN       = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        pc          = '0;
        flush       = 1'b0;
        checking    = 1'b0;
        checks      = 0;
        valueErrors = 0;
        otherErrors = 0;
        resultSeen  = 0;
        jumpSeen    = 0;
        sysSeen     = 0;
        flushSeen   = 0;
        pcNext      = 32'h0040_0000;
        for (int n = 0; n < `REG_N; n++)
            modelRegs[n] = '0;
        for (int n = 0; n < 4; n++)
        begin
            expKind[n] = EV_NONE;
            expData[n] = '0;
            expReg[n]  = '0;
            expV[n]    = '0;
            expA[n]    = '0;
        end
        repeat (10) @(negedge clk);
        arstN    = 1'b1;
        checking = 1'b1;

        // three idle cycles at the end drain the pipeline
        for (int i = 0; i < NUM_INSTR + 3; i++)
        begin
            @(negedge clk);
            slot    = 2'(cycleCount + 2);
            doIssue = 1'b0;
            doFlush = 1'b0;
            if (i < NUM_INSTR)
            begin
                r       = $random(seed);
                doIssue = r[2:0] != 3'd0;
                doFlush = r[7:4] == 4'd0;
            end
            instrValid    = doIssue;
            flush         = doFlush;
            expKind[slot] = EV_NONE;
            if (doIssue)
            begin
                w     = makeInstr();
                instr = w;
                pc    = pcNext;
                if (doFlush)
                    flushSeen++;
                else
                    modelInstr(w, pcNext, expKind[slot], expData[slot], expReg[slot],
                               expV[slot], expA[slot]);
                pcNext = pcNext + 32'd4;
            end
        end
        @(posedge clk);
        checking = 1'b0;

        assert (resultSeen > 0 && jumpSeen > 0 && sysSeen > 0 && flushSeen > 0)
        else
        begin
            $display("some kind of strobe or a flushed instruction never occurred");
            otherErrors++;
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* mipsCore.f */
+incdir+design
design/mipsCorePkg.sv
design/regFile.sv
design/instrDecoder.sv
design/decodeExecReg.sv
design/execUnit.sv
design/mipsCore.sv
tb/mipsCore_asserts.sv
tb/mipsCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= mipsCore.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q '>>> FAIL' $(LOG)
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
